//--- build.f
src/msx_pkg.sv
src/cpu_port.sv
src/io_ports.sv
src/slot_memory.sv
src/audio_mixer.sv
src/msx_bus.sv
test/msx_bus_props.sv
test/tb_msx_bus.sv

//--- Bender.yml
package:
  name: msx_bus

sources:
  # RTL sources, package first
  - files:
      - src/msx_pkg.sv
      - src/cpu_port.sv
      - src/io_ports.sv
      - src/slot_memory.sv
      - src/audio_mixer.sv
      - src/msx_bus.sv
  # Testbench and bound assertions
  - target: test
    files:
      - test/msx_bus_props.sv
      - test/tb_msx_bus.sv

//--- test/tb_msx_bus.sv
module tb_msx_bus
   import msx_pkg::*;
();

   localparam int clk_period   = 20;
   localparam int num_rows     = 26;
   localparam int ack_limit    = 16;
   localparam int timeout_time = (num_rows * 10 + 20) * clk_period;

   // One bus cycle with the audio inputs held during it
   typedef struct {
      bus_op_t op;
      addr_t   addr;
      data_t   wdata;
      sample_t psg;
      logic    tape_in;
      data_t   exp_rdata;
      sample_t exp_audio;
      logic    exp_motor;
   } row_t;

   logic    clock_bus;
   logic    arst_n;
   logic    req;
   bus_op_t op;
   addr_t   addr;
   data_t   wdata;
   logic    ack;
   data_t   rdata;
   sample_t psg_sample;
   logic    tape_in;
   logic    tape_motor_on;
   sample_t audio;

   row_t  stim [num_rows];
   data_t rnd [3];
   int    n_checks;
   int    n_errors;
   int    n_assert;

   msx_bus #(
      .ram_slots (4'b1100)
   ) msx_bus_i (
      .clock_bus     (clock_bus),
      .arst_n        (arst_n),
      .req           (req),
      .op            (op),
      .addr          (addr),
      .wdata         (wdata),
      .ack           (ack),
      .rdata         (rdata),
      .psg_sample    (psg_sample),
      .tape_in       (tape_in),
      .tape_motor_on (tape_motor_on),
      .audio         (audio)
   );

   bind cpu_port msx_bus_props props_i (
      .clock_bus (clock_bus),
      .arst_n    (arst_n),
      .req       (req),
      .ack       (ack),
      .strobe    (strobe)
   );

   always #(clk_period / 2) clock_bus = ~clock_bus;

   initial begin
      #(timeout_time);
      $display("Watchdog expired: run did not finish within %0d time units", timeout_time);
      $display("FAIL: see errors above");
      $finish;
   end

   task automatic check_data(input string what, input data_t got, input data_t exp);
      n_checks++;
      if (got !== exp) begin
         n_errors++;
         $display("Fail at %0t: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_sample(input string what, input sample_t got, input sample_t exp);
      n_checks++;
      if (got !== exp) begin
         n_errors++;
         $display("Fail at %0t: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_flag(input string what, input logic got, input logic exp);
      n_checks++;
      if (got !== exp) begin
         n_errors++;
         $display("Fail at %0t: %s is %b, expected %b", $time, what, got, exp);
      end
   endtask

   task automatic check_latency(input string what, input int got, input int exp);
      n_checks++;
      if (got != exp) begin
         n_errors++;
         $display("Fail at %0t: %s is %0d cycles, expected %0d", $time, what, got, exp);
      end
   endtask

   // Audio = psg + 512 with click + 256 with tape_in while motor off, clamped to 16 bits
   // Slot register C0 maps page 3 to slot 3, 80 to slot 2, C4 also page 1 to slot 1
   function automatic void build_table();
      stim[0]  = '{op_io_wr,  16'h00A8, 8'hC0,  16'sh0000, 1'b0, 8'h00,  16'sh0000, 1'b0};
      stim[1]  = '{op_io_rd,  16'h00A8, 8'h00,  16'sh0000, 1'b0, 8'hC0,  16'sh0000, 1'b0};
      stim[2]  = '{op_mem_wr, 16'hC010, rnd[0], 16'sh0000, 1'b0, 8'h00,  16'sh0000, 1'b0};
      stim[3]  = '{op_mem_rd, 16'hC010, 8'h00,  16'sh0000, 1'b0, rnd[0], 16'sh0000, 1'b0};
      stim[4]  = '{op_fetch,  16'hC010, 8'h00,  16'sh0000, 1'b0, rnd[0], 16'sh0000, 1'b0};
      stim[5]  = '{op_mem_wr, 16'hFFFF, rnd[2], 16'sh0000, 1'b0, 8'h00,  16'sh0000, 1'b0};
      stim[6]  = '{op_io_wr,  16'h00A8, 8'h80,  16'sh0000, 1'b0, 8'h00,  16'sh0000, 1'b0};
      stim[7]  = '{op_mem_wr, 16'hC010, rnd[1], 16'sh0000, 1'b0, 8'h00,  16'sh0000, 1'b0};
      stim[8]  = '{op_mem_rd, 16'hC010, 8'h00,  16'sh0000, 1'b0, rnd[1], 16'sh0000, 1'b0};
      stim[9]  = '{op_io_rd,  16'h00A8, 8'h00,  16'sh0000, 1'b0, 8'h80,  16'sh0000, 1'b0};
      stim[10] = '{op_io_wr,  16'h00A8, 8'hC0,  16'sh0000, 1'b0, 8'h00,  16'sh0000, 1'b0};
      stim[11] = '{op_mem_rd, 16'hC010, 8'h00,  16'sh0000, 1'b0, rnd[0], 16'sh0000, 1'b0};
      stim[12] = '{op_fetch,  16'hFFFF, 8'h00,  16'sh0000, 1'b0, rnd[2], 16'sh0000, 1'b0};
      // Open bus in empty slots and on unused ports
      stim[13] = '{op_mem_rd, 16'h1234, 8'h00,  16'sh0000, 1'b0, 8'hFF,  16'sh0000, 1'b0};
      stim[14] = '{op_io_wr,  16'h00A8, 8'hC4,  16'sh0000, 1'b0, 8'h00,  16'sh0000, 1'b0};
      stim[15] = '{op_mem_rd, 16'h4000, 8'h00,  16'sh0000, 1'b0, 8'hFF,  16'sh0000, 1'b0};
      stim[16] = '{op_fetch,  16'h0000, 8'h00,  16'sh0000, 1'b0, 8'hFF,  16'sh0000, 1'b0};
      stim[17] = '{op_io_rd,  16'h0098, 8'h00,  16'sh0000, 1'b0, 8'hFF,  16'sh0000, 1'b0};
      // PPI port C, click and motor
      stim[18] = '{op_io_wr,  16'h00AA, 8'h90,  16'sh0100, 1'b1, 8'h00,  16'sh0400, 1'b0};
      stim[19] = '{op_io_rd,  16'h00AA, 8'h00,  16'sh0100, 1'b1, 8'h90,  16'sh0400, 1'b0};
      stim[20] = '{op_io_wr,  16'h00AA, 8'h80,  16'sh0100, 1'b1, 8'h00,  16'sh0300, 1'b1};
      // Saturation at both ends
      stim[21] = '{op_io_rd,  16'h00AA, 8'h00,  16'sh7F00, 1'b1, 8'h80,  16'sh7FFF, 1'b1};
      stim[22] = '{op_io_wr,  16'h00AA, 8'h10,  16'sh8000, 1'b0, 8'h00,  16'sh8000, 1'b0};
      stim[23] = '{op_io_rd,  16'h00AA, 8'h00,  16'sh8010, 1'b1, 8'h10,  16'sh8110, 1'b0};
      stim[24] = '{op_io_wr,  16'h00AA, 8'h90,  16'sh8000, 1'b1, 8'h00,  16'sh8300, 1'b0};
      stim[25] = '{op_io_rd,  16'h00AA, 8'h00,  16'sh7FF0, 1'b1, 8'h90,  16'sh7FFF, 1'b0};
   endfunction

   // Full four-phase cycle for one table row
   task automatic run_row(input int idx);
      row_t  r;
      int    cycles;
      string tag;
      r   = stim[idx];
      tag = $sformatf("row %0d", idx);
      @(negedge clock_bus);
      op         = r.op;
      addr       = r.addr;
      wdata      = r.wdata;
      psg_sample = r.psg;
      tape_in    = r.tape_in;
      req        = 1'b1;
      cycles     = 0;
      do begin
         @(negedge clock_bus);
         cycles++;
      end while (!ack && cycles < ack_limit);
      if (!ack) begin
         n_errors++;
         $display("Timeout: no ack from the DUT within %0d cycles on %s", ack_limit, tag);
      end else begin
         check_latency({tag, " ack latency"}, cycles, (r.op == op_fetch) ? 4 : 3);
         if (r.op == op_mem_rd || r.op == op_io_rd || r.op == op_fetch)
            check_data({tag, " rdata"}, rdata, r.exp_rdata);
         check_sample({tag, " audio"}, audio, r.exp_audio);
         check_flag({tag, " tape_motor_on"}, tape_motor_on, r.exp_motor);
      end
      req    = 1'b0;
      cycles = 0;
      while (ack && cycles < ack_limit) begin
         @(negedge clock_bus);
         cycles++;
      end
      if (ack) begin
         n_errors++;
         $display("Timeout: ack still high %0d cycles after req dropped on %s", ack_limit, tag);
      end
   endtask

   initial begin
      void'($urandom(32'hb9e8));
      clock_bus  = 1'b0;
      arst_n     = 1'b0;
      req        = 1'b0;
      op         = op_mem_rd;
      addr       = '0;
      wdata      = '0;
      psg_sample = '0;
      tape_in    = 1'b0;
      n_checks   = 0;
      n_errors   = 0;
      for (int i = 0; i < 3; i++)
         rnd[i] = 8'($urandom);
      // Slot 2 and slot 3 must hold different bytes at the same address
      if (rnd[1] == rnd[0])
         rnd[1] = ~rnd[0];
      build_table();
      repeat (3) @(negedge clock_bus);
      arst_n = 1'b1;
      @(negedge clock_bus);
      check_flag("ack after reset", ack, 1'b0);
      check_sample("audio after reset", audio, 16'sh0000);
      check_flag("tape_motor_on after reset", tape_motor_on, 1'b0);
      for (int i = 0; i < num_rows; i++)
         run_row(i);
      repeat (2) @(negedge clock_bus);
      n_assert = msx_bus_i.cpu_port_i.props_i.fail_count;
      $display("Checks: %0d, errors: %0d, assertion failures: %0d", n_checks, n_errors, n_assert);
      if (n_errors == 0 && n_assert == 0)
         $display("PASS: all tests");
      else
         $display("FAIL: see errors above");
      $finish;
   end

endmodule

//--- test/msx_bus_props.sv
module msx_bus_props (
   input logic clock_bus,
   input logic arst_n,
   input logic req,
   input logic ack,
   input logic strobe
);

   int fail_count = 0;

   // First cycle out of reset
   ack_low_after_reset: assert property (@(posedge clock_bus) $rose(arst_n) |-> !ack)
      else begin
         $error("ack high in the first cycle after reset");
         fail_count++;
      end

   ack_rise_needs_req: assert property (@(posedge clock_bus) disable iff (!arst_n)
      $rose(ack) |-> $past(req))
      else begin
         $error("ack rose while req was low");
         fail_count++;
      end

   ack_fall_after_req: assert property (@(posedge clock_bus) disable iff (!arst_n)
      $fell(ack) |-> !$past(req))
      else begin
         $error("ack fell before req was dropped");
         fail_count++;
      end

   // One strobe per request, one cycle wide
   strobe_single: assert property (@(posedge clock_bus) disable iff (!arst_n)
      strobe |=> !strobe)
      else begin
         $error("strobe held longer than one cycle");
         fail_count++;
      end

   strobe_per_req: assert property (@(posedge clock_bus) disable iff (!arst_n)
      $rose(req) |=> strobe)
      else begin
         $error("no strobe in the cycle after a new request");
         fail_count++;
      end

endmodule

//--- src/msx_bus.sv
module msx_bus
   import msx_pkg::*;
#(
   parameter logic [3:0] ram_slots = 4'b1100
) (
   input  logic    clock_bus,
   input  logic    arst_n,
   // Bus master handshake
   input  logic    req,
   input  bus_op_t op,
   input  addr_t   addr,
   input  data_t   wdata,
   output logic    ack,
   output data_t   rdata,
   // Audio and cassette
   input  sample_t psg_sample,
   input  logic    tape_in,
   output logic    tape_motor_on,
   output sample_t audio
);

   logic      strobe;
   addr_t     bus_addr;
   data_t     bus_wdata;
   logic      bus_wr;
   logic      bus_io;
   data_t     io_rdata;
   logic      io_oe;
   data_t     mem_rdata;
   logic      mem_oe;
   slot_cfg_t slot_cfg;
   logic      keyclick;

   cpu_port cpu_port_i (
      .clock_bus (clock_bus),
      .arst_n    (arst_n),
      .req       (req),
      .op        (op),
      .addr      (addr),
      .wdata     (wdata),
      .ack       (ack),
      .rdata     (rdata),
      .strobe    (strobe),
      .bus_addr  (bus_addr),
      .bus_wdata (bus_wdata),
      .bus_wr    (bus_wr),
      .bus_io    (bus_io),
      .io_rdata  (io_rdata),
      .io_oe     (io_oe),
      .mem_rdata (mem_rdata),
      .mem_oe    (mem_oe)
   );

   io_ports io_ports_i (
      .clock_bus     (clock_bus),
      .arst_n        (arst_n),
      .strobe        (strobe),
      .bus_addr      (bus_addr),
      .bus_wdata     (bus_wdata),
      .bus_wr        (bus_wr),
      .bus_io        (bus_io),
      .io_rdata      (io_rdata),
      .io_oe         (io_oe),
      .slot_cfg      (slot_cfg),
      .keyclick      (keyclick),
      .tape_motor_on (tape_motor_on)
   );

   slot_memory #(
      .ram_slots (ram_slots)
   ) slot_memory_i (
      .clock_bus (clock_bus),
      .arst_n    (arst_n),
      .strobe    (strobe),
      .bus_addr  (bus_addr),
      .bus_wdata (bus_wdata),
      .bus_wr    (bus_wr),
      .bus_io    (bus_io),
      .slot_cfg  (slot_cfg),
      .mem_rdata (mem_rdata),
      .mem_oe    (mem_oe)
   );

   audio_mixer audio_mixer_i (
      .clock_bus     (clock_bus),
      .arst_n        (arst_n),
      .psg_sample    (psg_sample),
      .keyclick      (keyclick),
      .tape_in       (tape_in),
      .tape_motor_on (tape_motor_on),
      .audio         (audio)
   );

endmodule

//--- src/audio_mixer.sv
module audio_mixer
   import msx_pkg::*;
(
   input  logic    clock_bus,
   input  logic    arst_n,
   input  sample_t psg_sample,
   input  logic    keyclick,
   input  logic    tape_in,
   input  logic    tape_motor_on,
   output sample_t audio
);

   logic signed [16:0] click_add;
   logic signed [16:0] tape_add;
   logic signed [16:0] mix;
   sample_t            mix_sat;

   assign click_add = keyclick ? {1'b0, keyclick_weight} : '0;

   // Tape input is only monitored while the motor is stopped
   assign tape_add = (tape_in && !tape_motor_on) ? {1'b0, tape_weight} : '0;

   // One guard bit is enough for three terms of this size
   assign mix = {psg_sample[15], psg_sample} + click_add + tape_add;

   always_comb begin
      case (mix[16:15])
         2'b01:   mix_sat = 16'sh7FFF;
         2'b10:   mix_sat = 16'sh8000;
         default: mix_sat = mix[15:0];
      endcase
   end

   always_ff @(posedge clock_bus or negedge arst_n) begin
      if (!arst_n)
         audio <= '0;
      else
         audio <= mix_sat;
   end

endmodule

//--- src/slot_memory.sv
module slot_memory
   import msx_pkg::*;
#(
   parameter logic [3:0] ram_slots = 4'b1100
) (
   input  logic      clock_bus,
   input  logic      arst_n,
   // Internal access bus
   input  logic      strobe,
   input  addr_t     bus_addr,
   input  data_t     bus_wdata,
   input  logic      bus_wr,
   input  logic      bus_io,
   // Primary slot register
   input  slot_cfg_t slot_cfg,
   // Read data back to the CPU side
   output data_t     mem_rdata,
   output logic      mem_oe
);

   logic [1:0] active_slot;
   logic [1:0] slot_q;
   logic       mem_cycle;
   data_t      slot_rdata [4];

   assign mem_cycle = strobe & ~bus_io;

   // Page is the top two address bits
   always_comb begin
      case (bus_addr[15:14])
         2'd0:    active_slot = slot_cfg[1:0];
         2'd1:    active_slot = slot_cfg[3:2];
         2'd2:    active_slot = slot_cfg[5:4];
         default: active_slot = slot_cfg[7:6];
      endcase
   end

   for (genvar s = 0; s < 4; s++) begin : g_slot
      if (ram_slots[s]) begin : g_ram
         // Full 64 KB per populated slot
         data_t ram [65536];
         data_t rd_q;

         always_ff @(posedge clock_bus) begin
            if (mem_cycle && active_slot == 2'(s)) begin
               if (bus_wr)
                  ram[bus_addr] <= bus_wdata;
               rd_q <= ram[bus_addr];
            end
         end

         assign slot_rdata[s] = rd_q;
      end else begin : g_empty
         assign slot_rdata[s] = 8'hFF;
      end
   end

   // Remember which slot answered the last access
   always_ff @(posedge clock_bus) begin
      if (mem_cycle)
         slot_q <= active_slot;
   end

   // I/O cycles clear the flag so they never pick up stale memory data
   always_ff @(posedge clock_bus or negedge arst_n) begin
      if (!arst_n)
         mem_oe <= 1'b0;
      else if (strobe)
         mem_oe <= ~bus_io & ram_slots[active_slot];
   end

   assign mem_rdata = slot_rdata[slot_q];

endmodule

//--- src/io_ports.sv
module io_ports
   import msx_pkg::*;
(
   input  logic      clock_bus,
   input  logic      arst_n,
   // Internal access bus
   input  logic      strobe,
   input  addr_t     bus_addr,
   input  data_t     bus_wdata,
   input  logic      bus_wr,
   input  logic      bus_io,
   // Read data back to the CPU side
   output data_t     io_rdata,
   output logic      io_oe,
   // System controls
   output slot_cfg_t slot_cfg,
   output logic      keyclick,
   output logic      tape_motor_on
);

   slot_cfg_t slot_reg;
   data_t     ppi_c;
   logic      io_cycle;
   logic      sel_slot;
   logic      sel_ppi_c;

   // Z80 I/O space only decodes the low address byte
   assign io_cycle  = strobe & bus_io;
   assign sel_slot  = (bus_addr[7:0] == port_slot);
   assign sel_ppi_c = (bus_addr[7:0] == port_ppi_c);

   // Port C resets with the motor-off bit set, so the motor starts stopped
   always_ff @(posedge clock_bus or negedge arst_n) begin
      if (!arst_n) begin
         slot_reg <= '0;
         ppi_c    <= 8'h10;
      end else if (io_cycle && bus_wr) begin
         if (sel_slot)
            slot_reg <= bus_wdata;
         if (sel_ppi_c)
            ppi_c <= bus_wdata;
      end
   end

   always_comb begin
      io_rdata = 8'hFF;
      if (sel_slot)
         io_rdata = slot_reg;
      else if (sel_ppi_c)
         io_rdata = ppi_c;
   end

   // Claim the read only for ports this block owns
   assign io_oe = io_cycle & ~bus_wr & (sel_slot | sel_ppi_c);

   assign slot_cfg = slot_reg;

   // Low nibble of port C selects the keyboard row, not used here
   assign keyclick      = ppi_c[7];
   assign tape_motor_on = ~ppi_c[4];

endmodule

//--- src/cpu_port.sv
module cpu_port
   import msx_pkg::*;
(
   input  logic    clock_bus,
   input  logic    arst_n,
   // Four-phase request from the external master
   input  logic    req,
   input  bus_op_t op,
   input  addr_t   addr,
   input  data_t   wdata,
   output logic    ack,
   output data_t   rdata,
   // Internal access bus
   output logic    strobe,
   output addr_t   bus_addr,
   output data_t   bus_wdata,
   output logic    bus_wr,
   output logic    bus_io,
   // Read data sources
   input  data_t   io_rdata,
   input  logic    io_oe,
   input  data_t   mem_rdata,
   input  logic    mem_oe
);

   typedef enum logic [2:0] {
      st_idle,
      st_access,
      st_capture,
      st_m1_wait,
      st_ack,
      st_release
   } state_t;

   state_t state;
   state_t state_nxt;
   logic   fetch_q;
   data_t  io_data_q;
   logic   io_oe_q;

   always_comb begin
      state_nxt = state;
      case (state)
         st_idle: begin
            // New cycle only starts with ack low, which holds in idle
            if (req)
               state_nxt = st_access;
         end
         st_access:  state_nxt = st_capture;
         // MSX inserts one extra wait on every opcode fetch
         st_capture: state_nxt = fetch_q ? st_m1_wait : st_ack;
         st_m1_wait: state_nxt = st_ack;
         st_ack: begin
            if (!req)
               state_nxt = st_release;
         end
         st_release: state_nxt = st_idle;
         default:    state_nxt = st_idle;
      endcase
   end

   always_ff @(posedge clock_bus or negedge arst_n) begin
      if (!arst_n) begin
         state <= st_idle;
         ack   <= 1'b0;
      end else begin
         state <= state_nxt;
         ack   <= (state_nxt == st_ack) || (state_nxt == st_release);
      end
   end

   // Request fields held for the whole cycle
   always_ff @(posedge clock_bus) begin
      if (state == st_idle && req) begin
         bus_addr  <= addr;
         bus_wdata <= wdata;
         bus_wr    <= (op == op_mem_wr) || (op == op_io_wr);
         bus_io    <= (op == op_io_rd) || (op == op_io_wr);
         fetch_q   <= (op == op_fetch);
      end
   end

   // I/O data is only valid during the strobe, keep it for the capture cycle
   always_ff @(posedge clock_bus) begin
      if (state == st_access) begin
         io_data_q <= io_rdata;
         io_oe_q   <= io_oe;
      end
   end

   // Device data wins over slot data, open bus reads FF
   always_ff @(posedge clock_bus) begin
      if (state == st_capture && !bus_wr) begin
         if (io_oe_q)
            rdata <= io_data_q;
         else if (mem_oe)
            rdata <= mem_rdata;
         else
            rdata <= 8'hFF;
      end
   end

   assign strobe = (state == st_access);

endmodule

//--- src/msx_pkg.sv
package msx_pkg;

   // CPU address and data bus
   typedef logic [15:0] addr_t;
   typedef logic [7:0]  data_t;

   // One bus cycle as issued by the master
   // op_fetch is a memory read with M1 active
   typedef enum logic [2:0] {
      op_mem_rd,
      op_mem_wr,
      op_io_rd,
      op_io_wr,
      op_fetch
   } bus_op_t;

   // Primary slot register, two bits per 16 KB page
   // Bits 1:0 select the slot of page 0, bits 7:6 the slot of page 3
   typedef logic [7:0] slot_cfg_t;

   // Signed audio sample
   typedef logic signed [15:0] sample_t;

   // I/O port of the primary slot register
   localparam logic [7:0] port_slot = 8'hA8;

   // I/O port of PPI port C
   // Bit 7 key click, bit 4 cassette motor off
   localparam logic [7:0] port_ppi_c = 8'hAA;

   // Audio weights of the system sounds
   localparam logic [15:0] keyclick_weight = 16'd512;
   localparam logic [15:0] tape_weight     = 16'd256;

endpackage
